/* src/rat_arch_pkg.sv */
package rat_arch_pkg;

  // architectural register number is bank:entry
  localparam int BANK_WIDTH = 2;
  localparam int ENTRY_WIDTH = 3;
  localparam int ENTRIES_PER_BANK = 8;

  // dependency reads name a slot of the current rename group
  localparam int SLOT_WIDTH = 4;
  localparam logic [1:0] DEP_MARKER = 2'b11;

  typedef struct packed {
    logic [BANK_WIDTH-1:0]  bank;
    logic [ENTRY_WIDTH-1:0] entry;
  } arch_reg_t;

  // top bit clear selects a table read
  typedef struct packed {
    logic      zero;
    arch_reg_t areg;
  } arch_view_t;

  // marker 11 selects the bypass, marker 10 is reserved
  typedef struct packed {
    logic [1:0]            marker;
    logic [SLOT_WIDTH-1:0] slot;
  } dep_view_t;

  // one 6-bit read address decoded either way
  typedef union packed {
    arch_view_t arch;
    dep_view_t  dep;
  } read_addr_u;

endpackage

/* src/rat_rename_pkg.sv */
package rat_rename_pkg;

  localparam int TAG_WIDTH = 9;
  localparam int FUNIT_WIDTH = 10;

  typedef logic [TAG_WIDTH-1:0]   rob_tag_t;
  typedef logic [FUNIT_WIDTH-1:0] funit_t;

  // idle mapping with no producer in flight
  localparam rob_tag_t TAG_RESET = '1;
  localparam funit_t FUNIT_RESET = 10'h1FF;

  // one slot of a rename group
  typedef struct packed {
    logic                  wen;
    rat_arch_pkg::arch_reg_t dest;
    rob_tag_t              tag;
    funit_t                funit;
  } rename_slot_t;

  typedef struct packed {
    logic     wen;
    rob_tag_t tag;
  } retire_port_t;

  // stored per register and per thread
  typedef struct packed {
    rob_tag_t tag;
    funit_t   funit;
    logic     retired;
  } map_entry_t;

  typedef struct packed {
    rob_tag_t tag;
    funit_t   funit;
    logic     retired;
    logic     is_dep;
  } read_result_t;

endpackage

/* src/rat_entry.sv */
`timescale 1ns/10ps

module rat_entry #(
  parameter int INDEX = 0,
  parameter int NUM_SLOTS = 3,
  parameter int NUM_RET = 3
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_en,
  input  rat_rename_pkg::rename_slot_t slots [NUM_SLOTS],
  input  rat_rename_pkg::retire_port_t ret_ports [NUM_RET],
  input  logic                        ret_thread,
  input  logic                        retire_all,
  input  logic                        retire_all_thread,
  input  logic                        thread_q,
  output rat_rename_pkg::map_entry_t   state [2]
);

  localparam rat_arch_pkg::arch_reg_t REG_ID =
    INDEX[$bits(rat_arch_pkg::arch_reg_t)-1:0];

  localparam rat_rename_pkg::map_entry_t RESET_ENTRY = '{
    tag:     rat_rename_pkg::TAG_RESET,
    funit:   rat_rename_pkg::FUNIT_RESET,
    retired: 1'b1
  };

  logic                     new_hit;
  rat_rename_pkg::rob_tag_t new_tag;
  rat_rename_pkg::funit_t   new_funit;
  logic                     ret_match;
  logic [1:0]               rename_hit;
  logic [1:0]               ret_hit;
  logic [1:0]               all_hit;

  // later slots overwrite earlier ones, so the highest slot wins
  always_comb
  begin
    new_hit = 1'b0;
    new_tag = slots[0].tag;
    new_funit = slots[0].funit;
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      if (wr_en && slots[s].wen && slots[s].dest == REG_ID)
      begin
        new_hit = 1'b1;
        new_tag = slots[s].tag;
        new_funit = slots[s].funit;
      end
    end
  end

  // retire compares against the retiring thread's copy only
  always_comb
  begin
    ret_match = 1'b0;
    for (int r = 0; r < NUM_RET; r++)
    begin
      if (ret_ports[r].wen && ret_ports[r].tag == state[ret_thread].tag)
        ret_match = 1'b1;
    end
  end

  always_comb
  begin
    for (int t = 0; t < 2; t++)
    begin
      rename_hit[t] = new_hit && (thread_q == 1'(t));
      ret_hit[t] = ret_match && (ret_thread == 1'(t));
      all_hit[t] = retire_all && (retire_all_thread == 1'(t));
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int t = 0; t < 2; t++)
        state[t] <= RESET_ENTRY;
    end
    else
    begin
      for (int t = 0; t < 2; t++)
      begin
        if (rename_hit[t])
        begin
          state[t].tag <= new_tag;
          state[t].funit <= new_funit;
        end
        // retire-all beats rename, rename beats a single retire
        if (all_hit[t])
          state[t].retired <= 1'b1;
        else if (rename_hit[t])
          state[t].retired <= 1'b0;
        else if (ret_hit[t])
          state[t].retired <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) rst |=> state[0] == RESET_ENTRY && state[1] == RESET_ENTRY)
    else $error("rat_entry %0d: thread copies not at reset value after reset", INDEX);

endmodule

/* src/rat_bank.sv */
`timescale 1ns/10ps

module rat_bank #(
  parameter int BANK = 0,
  parameter int NUM_SLOTS = 3,
  parameter int NUM_READ = 4,
  parameter int NUM_RET = 3
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wr_en,
  input  rat_rename_pkg::rename_slot_t      slots [NUM_SLOTS],
  input  rat_rename_pkg::retire_port_t      ret_ports [NUM_RET],
  input  logic                             ret_thread,
  input  logic                             retire_all,
  input  logic                             retire_all_thread,
  input  logic                             thread_q,
  input  logic [rat_arch_pkg::ENTRY_WIDTH-1:0] entry_sel [NUM_READ],
  output rat_rename_pkg::map_entry_t        rd_entry [NUM_READ]
);

  rat_rename_pkg::map_entry_t ent_state [rat_arch_pkg::ENTRIES_PER_BANK][2];

  // register number of entry e is BANK*8+e
  for (genvar e = 0; e < rat_arch_pkg::ENTRIES_PER_BANK; e++)
  begin : g_entry
    rat_entry #(
      .INDEX(BANK * rat_arch_pkg::ENTRIES_PER_BANK + e),
      .NUM_SLOTS(NUM_SLOTS),
      .NUM_RET(NUM_RET)
    ) entry_i (
      .clk(clk),
      .rst(rst),
      .wr_en(wr_en),
      .slots(slots),
      .ret_ports(ret_ports),
      .ret_thread(ret_thread),
      .retire_all(retire_all),
      .retire_all_thread(retire_all_thread),
      .thread_q(thread_q),
      .state(ent_state[e])
    );
  end

  // each read port picks its entry, then the registered thread's copy
  for (genvar p = 0; p < NUM_READ; p++)
  begin : g_read
    assign rd_entry[p] = ent_state[entry_sel[p]][thread_q];
  end

endmodule

/* src/rat_read_stage.sv */
`timescale 1ns/10ps

module rat_read_stage #(
  parameter int NUM_SLOTS = 3,
  parameter int NUM_READ = 4,
  parameter int NUM_BANKS = 4
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 read_clkEn,
  input  rat_arch_pkg::read_addr_u              read_addr [NUM_READ],
  input  logic                                 thread,
  input  rat_rename_pkg::rename_slot_t          slots [NUM_SLOTS],
  input  rat_rename_pkg::map_entry_t            bank_entry [NUM_BANKS][NUM_READ],
  output logic [rat_arch_pkg::ENTRY_WIDTH-1:0] entry_sel [NUM_READ],
  output logic                                 thread_q,
  output rat_rename_pkg::read_result_t          result [NUM_READ]
);

  rat_arch_pkg::read_addr_u   addr_q [NUM_READ];
  logic [NUM_READ-1:0]        is_dep;
  rat_rename_pkg::map_entry_t arch_sel [NUM_READ];
  rat_rename_pkg::rob_tag_t   dep_tag [NUM_READ];
  rat_rename_pkg::funit_t     dep_funit [NUM_READ];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < NUM_READ; p++)
        addr_q[p] <= '0;
      thread_q <= 1'b0;
    end
    else if (read_clkEn)
    begin
      for (int p = 0; p < NUM_READ; p++)
        addr_q[p] <= read_addr[p];
      thread_q <= thread;
    end
  end

  always_comb
  begin
    for (int p = 0; p < NUM_READ; p++)
    begin
      is_dep[p] = addr_q[p].dep.marker == rat_arch_pkg::DEP_MARKER;

      // bank mux over the banks that exist
      arch_sel[p] = bank_entry[0][p];
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        if (addr_q[p].arch.areg.bank == rat_arch_pkg::BANK_WIDTH'(b))
          arch_sel[p] = bank_entry[b][p];
      end

      // bypass from the rename group on the bus this cycle
      dep_tag[p] = slots[0].tag;
      dep_funit[p] = slots[0].funit;
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
        if (addr_q[p].dep.slot == rat_arch_pkg::SLOT_WIDTH'(s))
        begin
          dep_tag[p] = slots[s].tag;
          dep_funit[p] = slots[s].funit;
        end
      end

      if (is_dep[p])
        result[p] = '{tag: dep_tag[p], funit: dep_funit[p], retired: 1'b0, is_dep: 1'b1};
      else
        result[p] = '{tag: arch_sel[p].tag, funit: arch_sel[p].funit,
                      retired: arch_sel[p].retired, is_dep: 1'b0};
    end
  end

  for (genvar p = 0; p < NUM_READ; p++)
  begin : g_port
    assign entry_sel[p] = addr_q[p].arch.areg.entry;

    // marker 10 is reserved
    assert property (@(posedge clk) disable iff (rst)
      read_clkEn |=> addr_q[p].dep.marker != 2'b10)
      else $error("rat_read_stage: port %0d captured reserved address", p);

    assert property (@(posedge clk) disable iff (rst)
      read_clkEn |=> !is_dep[p] || addr_q[p].dep.slot < NUM_SLOTS)
      else $error("rat_read_stage: port %0d names a missing rename slot", p);

    assert property (@(posedge clk) disable iff (rst)
      read_clkEn |=> addr_q[p].arch.zero || addr_q[p].arch.areg.bank < NUM_BANKS)
      else $error("rat_read_stage: port %0d reads a missing bank", p);
  end

endmodule

/* src/rat.sv */
`timescale 1ns/10ps

module rat #(
  parameter int NUM_SLOTS = 3,
  parameter int NUM_READ = 4,
  parameter int NUM_RET = 3,
  parameter int NUM_BANKS = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         read_clkEn,
  input  rat_arch_pkg::read_addr_u      read_addr [NUM_READ],
  input  logic                         thread,
  input  rat_rename_pkg::rename_slot_t  slots [NUM_SLOTS],
  input  rat_rename_pkg::retire_port_t  ret_ports [NUM_RET],
  input  logic                         ret_thread,
  input  logic                         retire_all,
  input  logic                         retire_all_thread,
  output rat_rename_pkg::read_result_t  result [NUM_READ]
);

  logic [rat_arch_pkg::ENTRY_WIDTH-1:0] entry_sel [NUM_READ];
  logic                                 thread_q;
  rat_rename_pkg::map_entry_t           bank_entry [NUM_BANKS][NUM_READ];

  // rename writes share the read clock enable
  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    rat_bank #(
      .BANK(b),
      .NUM_SLOTS(NUM_SLOTS),
      .NUM_READ(NUM_READ),
      .NUM_RET(NUM_RET)
    ) bank_i (
      .clk(clk),
      .rst(rst),
      .wr_en(read_clkEn),
      .slots(slots),
      .ret_ports(ret_ports),
      .ret_thread(ret_thread),
      .retire_all(retire_all),
      .retire_all_thread(retire_all_thread),
      .thread_q(thread_q),
      .entry_sel(entry_sel),
      .rd_entry(bank_entry[b])
    );
  end

  rat_read_stage #(
    .NUM_SLOTS(NUM_SLOTS),
    .NUM_READ(NUM_READ),
    .NUM_BANKS(NUM_BANKS)
  ) read_stage_i (
    .clk(clk),
    .rst(rst),
    .read_clkEn(read_clkEn),
    .read_addr(read_addr),
    .thread(thread),
    .slots(slots),
    .bank_entry(bank_entry),
    .entry_sel(entry_sel),
    .thread_q(thread_q),
    .result(result)
  );

endmodule

/* testbench/rat_tb.sv */
`timescale 1ns/10ps

module rat_tb;

  localparam int NUM_SLOTS = 3;
  localparam int NUM_READ = 4;
  localparam int NUM_RET = 3;
  localparam int NUM_BANKS = 4;
  localparam int WAIT_LIMIT = 20;

  logic clk = 1'b0;
  logic rst;
  logic read_clkEn;
  logic thread;
  logic ret_thread;
  logic retire_all;
  logic retire_all_thread;
  rat_arch_pkg::read_addr_u       read_addr [NUM_READ];
  rat_rename_pkg::rename_slot_t   slots [NUM_SLOTS];
  rat_rename_pkg::retire_port_t   ret_ports [NUM_RET];
  rat_rename_pkg::read_result_t   result [NUM_READ];

  // reference table, registered address and thread
  rat_rename_pkg::map_entry_t   model [2][32];
  logic [5:0]                   model_addr [NUM_READ];
  logic                         model_thread;
  rat_rename_pkg::read_result_t exp_res [NUM_READ];

  int seed = 32'h08d8_a0ad;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int errors_at_start = 0;

  always #2 clk = ~clk;

  rat #(
    .NUM_SLOTS(NUM_SLOTS),
    .NUM_READ(NUM_READ),
    .NUM_RET(NUM_RET),
    .NUM_BANKS(NUM_BANKS)
  ) rat_i (
    .clk(clk),
    .rst(rst),
    .read_clkEn(read_clkEn),
    .read_addr(read_addr),
    .thread(thread),
    .slots(slots),
    .ret_ports(ret_ports),
    .ret_thread(ret_thread),
    .retire_all(retire_all),
    .retire_all_thread(retire_all_thread),
    .result(result)
  );

  // single retire first, then rename over it, then retire-all over both
  function automatic rat_rename_pkg::map_entry_t next_entry(input int t, input int r);
    rat_rename_pkg::map_entry_t e;
    e = model[t][r];
    if (t == int'(ret_thread))
      for (int k = 0; k < NUM_RET; k++)
        if (ret_ports[k].wen && ret_ports[k].tag == e.tag)
          e.retired = 1'b1;
    if (read_clkEn && t == int'(model_thread))
      for (int s = 0; s < NUM_SLOTS; s++)
        if (slots[s].wen && slots[s].dest == 5'(r))
          e = '{tag: slots[s].tag, funit: slots[s].funit, retired: 1'b0};
    if (retire_all && t == int'(retire_all_thread))
      e.retired = 1'b1;
    return e;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int t = 0; t < 2; t++)
        for (int r = 0; r < 32; r++)
          model[t][r] <= '{tag: '1, funit: 10'h1FF, retired: 1'b1};
      for (int p = 0; p < NUM_READ; p++)
        model_addr[p] <= '0;
      model_thread <= 1'b0;
    end
    else
    begin
      for (int t = 0; t < 2; t++)
        for (int r = 0; r < 32; r++)
          model[t][r] <= next_entry(t, r);
      if (read_clkEn)
      begin
        for (int p = 0; p < NUM_READ; p++)
          model_addr[p] <= read_addr[p];
        model_thread <= thread;
      end
    end
  end

  // marker 11 reads the slot on the bus now, top bit 0 reads the table
  always_comb
  begin
    for (int p = 0; p < NUM_READ; p++)
    begin
      if (model_addr[p][5:4] == 2'b11)
        exp_res[p] = '{tag: slots[model_addr[p][3:0]].tag,
                       funit: slots[model_addr[p][3:0]].funit, retired: 1'b0, is_dep: 1'b1};
      else
        exp_res[p] = '{tag: model[model_thread][model_addr[p][4:0]].tag,
                       funit: model[model_thread][model_addr[p][4:0]].funit,
                       retired: model[model_thread][model_addr[p][4:0]].retired, is_dep: 1'b0};
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
    errors++;
  endtask

  for (genvar p = 0; p < NUM_READ; p++)
  begin : g_check
    assert property (@(posedge clk) disable iff (rst) result[p].tag == exp_res[p].tag)
      else report_mismatch($sformatf("result[%0d].tag", p),
                           $sampled(result[p].tag), $sampled(exp_res[p].tag));
    assert property (@(posedge clk) disable iff (rst) result[p].funit == exp_res[p].funit)
      else report_mismatch($sformatf("result[%0d].funit", p),
                           $sampled(result[p].funit), $sampled(exp_res[p].funit));
    assert property (@(posedge clk) disable iff (rst) result[p].retired == exp_res[p].retired)
      else report_mismatch($sformatf("result[%0d].retired", p),
                           $sampled(result[p].retired), $sampled(exp_res[p].retired));
    assert property (@(posedge clk) disable iff (rst) result[p].is_dep == exp_res[p].is_dep)
      else report_mismatch($sformatf("result[%0d].is_dep", p),
                           $sampled(result[p].is_dep), $sampled(exp_res[p].is_dep));
  end

  task automatic idle_inputs();
    for (int s = 0; s < NUM_SLOTS; s++)
      slots[s] <= '0;
    for (int k = 0; k < NUM_RET; k++)
      ret_ports[k] <= '0;
    retire_all <= 1'b0;
  endtask

  task automatic read_arch(input int p, input int areg);
    read_addr[p] <= {1'b0, 5'(areg)};
  endtask

  task automatic read_dep(input int p, input int s);
    read_addr[p] <= {2'b11, 4'(s)};
  endtask

  task automatic set_slot(input int s, input int dest, input logic [8:0] tag,
                          input logic [9:0] funit);
    slots[s] <= {1'b1, 5'(dest), tag, funit};
  endtask

  task automatic retire_tag(input int k, input logic [8:0] tag);
    ret_ports[k] <= {1'b1, tag};
  endtask

  task automatic drive_random();
    logic [31:0] v;
    v = $random(seed);
    read_clkEn <= v[1:0] != 2'b00;
    thread <= v[2];
    ret_thread <= v[3];
    retire_all <= v[8:4] == 5'd0;
    retire_all_thread <= v[9];
    for (int p = 0; p < NUM_READ; p++)
    begin
      v = $random(seed);
      if (v[2:0] == 3'd0)
        read_dep(p, int'(v[4:3]) % NUM_SLOTS);
      else
        read_arch(p, int'(v[9:5]));
    end
    // small tag pool so retire ports hit stored tags
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      v = $random(seed);
      slots[s] <= {v[0], v[5:1], 9'(v[9:6]), v[19:10]};
    end
    for (int k = 0; k < NUM_RET; k++)
    begin
      v = $random(seed);
      ret_ports[k] <= {v[0] & v[1], 9'(v[5:2])};
    end
  endtask

  task automatic wait_result(input int p, input logic [8:0] tag, input logic [9:0] funit,
                             input logic retired, input logic is_dep);
    int n;
    n = 0;
    @(negedge clk);
    while (n < WAIT_LIMIT && result[p] !== {tag, funit, retired, is_dep})
    begin
      @(negedge clk);
      n++;
    end
    if (result[p] !== {tag, funit, retired, is_dep})
    begin
      $display("timeout at %0t: read port %0d never showed tag %h unit %h", $time, p, tag,
               funit);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors != errors_at_start)
      failed_tests++;
    $display("test %-10s %s, %0d errors", name, (errors == errors_at_start) ? "ok" : "FAILED",
             errors - errors_at_start);
  endtask

  initial
  begin
    rst = 1'b1;
    read_clkEn = 1'b0;
    thread = 1'b0;
    ret_thread = 1'b0;
    retire_all = 1'b0;
    retire_all_thread = 1'b0;
    for (int p = 0; p < NUM_READ; p++)
      read_addr[p] = '0;
    for (int s = 0; s < NUM_SLOTS; s++)
      slots[s] = '0;
    for (int k = 0; k < NUM_RET; k++)
      ret_ports[k] = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    read_clkEn <= 1'b1;

    start_test();
    for (int t = 0; t < 2; t++)
      for (int g = 0; g < 8; g++)
      begin
        @(posedge clk);
        idle_inputs();
        thread <= t[0];
        for (int p = 0; p < NUM_READ; p++)
          read_arch(p, g * NUM_READ + p);
        wait_result(NUM_READ - 1, 9'h1FF, 10'h1FF, 1'b1, 1'b0);
      end
    finish_test("reset");

    // slots 0 and 2 collide on r9 of thread 0
    start_test();
    @(posedge clk);
    idle_inputs();
    thread <= 1'b0;
    read_arch(0, 9);
    read_arch(1, 20);
    @(posedge clk);
    idle_inputs();
    set_slot(0, 9, 9'h011, 10'h101);
    set_slot(1, 20, 9'h022, 10'h102);
    set_slot(2, 9, 9'h033, 10'h103);
    @(posedge clk);
    idle_inputs();
    wait_result(0, 9'h033, 10'h103, 1'b0, 1'b0);
    wait_result(1, 9'h022, 10'h102, 1'b0, 1'b0);
    @(posedge clk);
    thread <= 1'b1;
    wait_result(0, 9'h1FF, 10'h1FF, 1'b1, 1'b0);
    finish_test("rename");

    start_test();
    @(posedge clk);
    read_arch(0, 3);
    read_arch(1, 4);
    read_arch(2, 9);
    @(posedge clk);
    set_slot(0, 3, 9'h044, 10'h201);
    set_slot(1, 4, 9'h055, 10'h202);
    @(posedge clk);
    idle_inputs();
    wait_result(0, 9'h044, 10'h201, 1'b0, 1'b0);
    // 033 lives only in thread 0, and r4 is renamed in the same cycle
    @(posedge clk);
    ret_thread <= 1'b1;
    retire_tag(0, 9'h044);
    retire_tag(1, 9'h033);
    retire_tag(2, 9'h055);
    set_slot(0, 4, 9'h066, 10'h203);
    @(posedge clk);
    idle_inputs();
    wait_result(0, 9'h044, 10'h201, 1'b1, 1'b0);
    wait_result(1, 9'h066, 10'h203, 1'b0, 1'b0);
    @(posedge clk);
    thread <= 1'b0;
    wait_result(2, 9'h033, 10'h103, 1'b0, 1'b0);
    finish_test("retire");

    start_test();
    @(posedge clk);
    read_arch(0, 12);
    read_arch(1, 9);
    read_arch(2, 4);
    @(posedge clk);
    set_slot(2, 12, 9'h077, 10'h301);
    retire_all <= 1'b1;
    retire_all_thread <= 1'b0;
    @(posedge clk);
    idle_inputs();
    wait_result(0, 9'h077, 10'h301, 1'b1, 1'b0);
    wait_result(1, 9'h033, 10'h103, 1'b1, 1'b0);
    @(posedge clk);
    thread <= 1'b1;
    wait_result(2, 9'h066, 10'h203, 1'b0, 1'b0);
    finish_test("retire_all");

    start_test();
    @(posedge clk);
    read_dep(0, 0);
    read_dep(1, 1);
    read_dep(2, 2);
    @(posedge clk);
    set_slot(0, 1, 9'h0a1, 10'h3a1);
    set_slot(1, 2, 9'h0a2, 10'h3a2);
    set_slot(2, 1, 9'h0a3, 10'h3a3);
    wait_result(0, 9'h0a1, 10'h3a1, 1'b0, 1'b1);
    wait_result(1, 9'h0a2, 10'h3a2, 1'b0, 1'b1);
    wait_result(2, 9'h0a3, 10'h3a3, 1'b0, 1'b1);
    @(posedge clk);
    idle_inputs();
    finish_test("bypass");

    start_test();
    @(posedge clk);
    read_arch(0, 1);
    @(posedge clk);
    wait_result(0, 9'h0a3, 10'h3a3, 1'b0, 1'b0);
    // with the enable low the address, thread and rename are all ignored
    @(posedge clk);
    read_clkEn <= 1'b0;
    thread <= 1'b0;
    read_arch(0, 2);
    set_slot(0, 1, 9'h0bb, 10'h3bb);
    repeat (4) @(posedge clk);
    idle_inputs();
    read_clkEn <= 1'b1;
    read_arch(0, 1);
    thread <= 1'b1;
    @(posedge clk);
    wait_result(0, 9'h0a3, 10'h3a3, 1'b0, 1'b0);
    finish_test("hold");

    start_test();
    for (int i = 0; i < 400; i++)
    begin
      @(posedge clk);
      drive_random();
    end
    @(posedge clk);
    idle_inputs();
    read_clkEn <= 1'b1;
    @(posedge clk);
    finish_test("random");

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* filelist.f */
src/rat_arch_pkg.sv
src/rat_rename_pkg.sv
src/rat_entry.sv
src/rat_bank.sv
src/rat_read_stage.sv
src/rat.sv
testbench/rat_tb.sv

/* Bender.yml */
package:
  name: rat

sources:
  - src/rat_arch_pkg.sv
  - src/rat_rename_pkg.sv
  - src/rat_entry.sv
  - src/rat_bank.sv
  - src/rat_read_stage.sv
  - src/rat.sv
  - target: test
    files:
      - testbench/rat_tb.sv
